//--- src.f
hdl/exe_pkg.sv
hdl/mem_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/mul_div.sv
hdl/mem_port.sv
hdl/exe_ctrl.sv
hdl/exe_stage.sv
test/tb_clock.sv
test/tb_exe_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage;

	// Tests take several hundred cycles, slow acks stretch the memory test
	localparam int MAX_CYCLES = 4000;

	typedef struct packed {
		logic wb, mis, redir, chk;
		logic [exe_pkg::REG_ADDR_W-1:0] rd;
		logic [exe_pkg::XLEN-1:0] data, tgt;
		int due; // Cycle of the result, -1 when latency varies
	} exp_t;

	logic clk, nrst;
	logic issue_valid;
	logic [exe_pkg::XLEN-1:0] op_a, op_b, imm, pc;
	logic [exe_pkg::REG_ADDR_W-1:0] rd;
	exe_pkg::alu_op_e alu_op;
	exe_pkg::br_kind_e br_kind;
	exe_pkg::mul_op_e mul_op;
	exe_pkg::wb_sel_e wb_sel;
	mem_pkg::mem_op_e mem_op;
	logic stall, wb_valid, redirect, misaligned, mem_req, mem_we;
	logic [exe_pkg::REG_ADDR_W-1:0] wb_rd;
	logic [exe_pkg::XLEN-1:0] wb_data, target;
	mem_pkg::mem_size_e mem_size;
	logic [mem_pkg::ADDR_W-1:0] mem_addr;
	logic [mem_pkg::DATA_W-1:0] mem_wdata;
	logic mem_ack = 1'b0;
	logic [mem_pkg::DATA_W-1:0] mem_rdata = '0;

	logic [mem_pkg::DATA_W-1:0] resp_mem [0:63];
	logic [mem_pkg::DATA_W-1:0] ref_mem [0:63];
	exp_t exp_q [$];
	exp_t cur;
	int seed = 16070;
	int ack_seed = 16070;
	int cycles = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int req_count = 0;
	int stall_waits = 0;
	int delay_left = -1;
	int i;

	tb_clock u_clk (.clk, .nrst);

	exe_stage dut (.*);

	task automatic check_data(input string name, input logic [exe_pkg::XLEN-1:0] expv, actv);
		if (actv !== expv)
		begin
			$display("FAILED %s: expected %h, got %h", name, expv, actv);
			errors++;
		end
	endtask

	task automatic check_rd(input string name, input logic [exe_pkg::REG_ADDR_W-1:0] expv, actv);
		if (actv !== expv)
		begin
			$display("FAILED %s: expected %h, got %h", name, expv, actv);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expv, input logic actv);
		if (actv !== expv)
		begin
			$display("FAILED %s: expected %h, got %h", name, expv, actv);
			errors++;
		end
	endtask

	function automatic logic [31:0] fill_word(input int idx);
		logic [7:0] x;
		x = 8'(idx);
		return {x ^ 8'h5a, ~x, x + 8'h31, x ^ 8'hc3};
	endfunction

	function automatic exp_t make_exp(input logic wb, mis, redir, chk,
		input logic [4:0] r, input logic [31:0] d, t, input logic timed);
		exp_t e;
		e.wb = wb;
		e.mis = mis;
		e.redir = redir;
		e.chk = chk;
		e.rd = r;
		e.data = d;
		e.tgt = t;
		e.due = timed ? 0 : -1;
		return e;
	endfunction

	function automatic logic [31:0] ref_alu(input exe_pkg::alu_op_e op, input logic [31:0] a, b);
		case (op)
			exe_pkg::ALU_ADD:  return a + b;
			exe_pkg::ALU_SUB:  return a - b;
			exe_pkg::ALU_SLL:  return a << b[4:0];
			exe_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exe_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			exe_pkg::ALU_XOR:  return a ^ b;
			exe_pkg::ALU_SRL:  return a >> b[4:0];
			exe_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
			exe_pkg::ALU_OR:   return a | b;
			default:           return a & b;
		endcase
	endfunction

	// 64-bit arithmetic, high half picked for the mulh family
	function automatic logic [31:0] ref_md(input exe_pkg::mul_op_e op, input logic [31:0] a, b);
		longint sa, sb, ua, ub;
		logic [63:0] p;
		logic hi, ovf;
		sa = $signed(a);
		sb = $signed(b);
		ua = {32'b0, a};
		ub = {32'b0, b};
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		hi = op inside {exe_pkg::MUL_MULH, exe_pkg::MUL_MULHSU, exe_pkg::MUL_MULHU};
		case (op)
			exe_pkg::MUL_MUL, exe_pkg::MUL_MULH: p = sa * sb;
			exe_pkg::MUL_MULHSU: p = sa * ub;
			exe_pkg::MUL_MULHU:  p = ua * ub;
			exe_pkg::MUL_DIV:    p = (b == 0) ? -1 : (ovf ? sa : sa / sb);
			exe_pkg::MUL_DIVU:   p = (b == 0) ? -1 : ua / ub;
			exe_pkg::MUL_REM:    p = (b == 0) ? sa : (ovf ? 0 : sa % sb);
			default:             p = (b == 0) ? ua : ua % ub;
		endcase
		return hi ? p[63:32] : p[31:0];
	endfunction

	function automatic logic ref_taken(input exe_pkg::br_kind_e bk, input logic [31:0] a, b);
		case (bk)
			exe_pkg::BR_BEQ:  return a == b;
			exe_pkg::BR_BNE:  return a != b;
			exe_pkg::BR_BLT:  return $signed(a) < $signed(b);
			exe_pkg::BR_BGE:  return $signed(a) >= $signed(b);
			exe_pkg::BR_BLTU: return a < b;
			exe_pkg::BR_BGEU: return a >= b;
			exe_pkg::BR_JAL, exe_pkg::BR_JALR: return 1'b1;
			default:          return 1'b0;
		endcase
	endfunction

	function automatic void ref_store(input logic [31:0] addr, input mem_pkg::mem_op_e mo,
		input logic [31:0] d);
		case (mo)
			mem_pkg::MEM_SB: ref_mem[addr[7:2]][8*addr[1:0] +: 8] = d[7:0];
			mem_pkg::MEM_SH: ref_mem[addr[7:2]][16*addr[1] +: 16] = d[15:0];
			default:         ref_mem[addr[7:2]] = d;
		endcase
	endfunction

	function automatic logic [31:0] ref_load(input logic [31:0] addr, input mem_pkg::mem_op_e mo);
		logic [31:0] w;
		logic [7:0] b8;
		logic [15:0] h;
		w = ref_mem[addr[7:2]];
		b8 = w[8*addr[1:0] +: 8];
		h = w[16*addr[1] +: 16];
		case (mo)
			mem_pkg::MEM_LB:  return {{24{b8[7]}}, b8};
			mem_pkg::MEM_LBU: return {24'b0, b8};
			mem_pkg::MEM_LH:  return {{16{h[15]}}, h};
			mem_pkg::MEM_LHU: return {16'b0, h};
			default:          return w;
		endcase
	endfunction

	// Aligned address inside the 64-word array
	function automatic logic [31:0] rand_addr(input mem_pkg::mem_op_e mo);
		logic [7:0] a8;
		a8 = 8'($random(seed));
		if (mo inside {mem_pkg::MEM_LH, mem_pkg::MEM_LHU, mem_pkg::MEM_SH})
			a8[0] = 1'b0;
		else if (mo inside {mem_pkg::MEM_LW, mem_pkg::MEM_SW})
			a8[1:0] = 2'b00;
		return {24'b0, a8};
	endfunction

	task automatic issue(input exe_pkg::alu_op_e aop, input exe_pkg::br_kind_e bk,
		input exe_pkg::mul_op_e mop, input exe_pkg::wb_sel_e ws, input mem_pkg::mem_op_e mo,
		input logic [31:0] a, b, im, p, input logic [4:0] r, input exp_t e);
		exp_t ent;
		@(negedge clk);
		issue_valid = 1'b1;
		alu_op = aop;
		br_kind = bk;
		mul_op = mop;
		wb_sel = ws;
		mem_op = mo;
		op_a = a;
		op_b = b;
		imm = im;
		pc = p;
		rd = r;
		#1;
		while (stall) // Hold inputs until accepted
		begin
			stall_waits++;
			@(negedge clk);
			#1;
		end
		ent = e;
		if (ent.due >= 0)
			ent.due = cycles + 2;
		exp_q.push_back(ent);
	endtask

	task automatic drain();
		@(negedge clk);
		issue_valid = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	task automatic report(input string name, input int err0);
		if (errors == err0)
		begin
			passed++;
			$display("Test %s: ok", name);
		end
		else
		begin
			failed++;
			$display("Test %s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic test_alu();
		int k, err0;
		logic [31:0] a, b;
		exe_pkg::alu_op_e op;
		err0 = errors;
		for (k = 0; k < 40; k++)
		begin
			op = exe_pkg::alu_op_e'(k % 10);
			a = $random(seed);
			b = $random(seed);
			issue(op, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_ALU, mem_pkg::MEM_NONE,
				a, b, 32'd0, 32'd0, 5'(k), make_exp(1, 0, 0, 1, 5'(k), ref_alu(op, a, b), 0, 1));
		end
		drain();
		report("alu", err0);
	endtask

	task automatic test_muldiv();
		int k, j, err0;
		logic [31:0] a, b;
		exe_pkg::mul_op_e mop;
		err0 = errors;
		for (k = 0; k < 8; k++)
			for (j = 0; j < 4; j++)
			begin
				mop = exe_pkg::mul_op_e'(k);
				a = $random(seed);
				b = $random(seed);
				if (j == 2)
					b = '0; // Divide by zero
				if (j == 3)
				begin
					a = 32'h8000_0000;
					b = 32'hffff_ffff;
				end
				issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, mop, exe_pkg::WB_MULDIV,
					mem_pkg::MEM_NONE, a, b, 32'd0, 32'd0, 5'(k*4+j),
					make_exp(1, 0, 0, 1, 5'(k*4+j), ref_md(mop, a, b), 0, 1));
			end
		drain();
		report("muldiv", err0);
	endtask

	task automatic test_branch();
		int k, j, err0;
		logic [31:0] a, b, im, p, tg;
		logic [31:0] pa [0:2];
		logic [31:0] pb [0:2];
		logic [4:0] r;
		exe_pkg::br_kind_e bk;
		err0 = errors;
		pa[0] = 32'd5;
		pb[0] = 32'd5;
		pa[1] = 32'hffff_fffd; // -3 against 7, both orders
		pb[1] = 32'd7;
		pa[2] = 32'd7;
		pb[2] = 32'hffff_fffd;
		for (k = 1; k <= 8; k++)
			for (j = 0; j < 3; j++)
			begin
				bk = exe_pkg::br_kind_e'(k);
				a = pa[j];
				b = pb[j];
				p = $random(seed) & 32'h0000_fffc;
				im = $random(seed) & 32'h0000_0ffe;
				r = (bk inside {exe_pkg::BR_JAL, exe_pkg::BR_JALR}) ? 5'(j + 1) : 5'd0;
				tg = (bk == exe_pkg::BR_JALR) ? ((a + im) & ~32'h1) : p + im;
				issue(exe_pkg::ALU_ADD, bk, exe_pkg::MUL_MUL, exe_pkg::WB_LINK, mem_pkg::MEM_NONE,
					a, b, im, p, r, make_exp(1, 0, ref_taken(bk, a, b), 1, r, p + 4, tg, 1));
			end
		drain();
		report("branch", err0);
	endtask

	task automatic test_upper();
		int k, err0;
		logic [31:0] im, p;
		exe_pkg::wb_sel_e ws;
		err0 = errors;
		for (k = 0; k < 16; k++)
		begin
			im = $random(seed) & 32'hffff_f000;
			p = $random(seed) & 32'hffff_fffc;
			ws = (k % 2 == 1) ? exe_pkg::WB_AUIPC : exe_pkg::WB_LUI;
			issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, ws, mem_pkg::MEM_NONE,
				32'd0, 32'd0, im, p, 5'(k + 1),
				make_exp(1, 0, 0, 1, 5'(k + 1), (ws == exe_pkg::WB_LUI) ? im : p + im, 0, 1));
		end
		drain();
		report("upper", err0);
	endtask

	task automatic test_loadstore();
		int k, err0, waits0;
		logic [31:0] addr, im, d;
		mem_pkg::mem_op_e mo;
		err0 = errors;
		waits0 = stall_waits;
		for (k = 0; k < 12; k++)
		begin
			mo = mem_pkg::mem_op_e'(6 + k % 3);
			addr = rand_addr(mo);
			im = $random(seed) % 16;
			d = $random(seed);
			ref_store(addr, mo, d);
			// Nonzero rd, the stage reports zero for stores
			issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_ALU, mo,
				addr - im, d, im, 32'd0, 5'd9, make_exp(1, 0, 0, 0, 5'd0, 0, 0, 0));
		end
		for (k = 0; k < 15; k++)
		begin
			mo = mem_pkg::mem_op_e'(1 + k % 5);
			addr = rand_addr(mo);
			im = $random(seed) % 16;
			d = $random(seed);
			issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_MEM, mo,
				addr - im, 32'd0, im, 32'd0, 5'(k + 1),
				make_exp(1, 0, 0, 1, 5'(k + 1), ref_load(addr, mo), 0, 0));
			issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_ALU,
				mem_pkg::MEM_NONE, d, 32'd1, 32'd0, 32'd0, 5'd31,
				make_exp(1, 0, 0, 1, 5'd31, d + 1, 0, 1));
		end
		drain();
		if (stall_waits == waits0)
		begin
			$display("Stall never held an instruction behind a memory access");
			errors++;
		end
		report("loadstore", err0);
	endtask

	task automatic test_misaligned();
		int err0, reqs0;
		exp_t e;
		err0 = errors;
		reqs0 = req_count;
		e = make_exp(0, 1, 0, 0, 5'd0, 0, 0, 1);
		issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_MEM,
			mem_pkg::MEM_LH, 32'h41, 32'd0, 32'd0, 32'd0, 5'd3, e);
		issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_MEM,
			mem_pkg::MEM_LW, 32'h40, 32'd0, 32'd2, 32'd0, 5'd4, e);
		issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_ALU,
			mem_pkg::MEM_SH, 32'h23, 32'h1234, 32'd0, 32'd0, 5'd0, e);
		issue(exe_pkg::ALU_ADD, exe_pkg::BR_NONE, exe_pkg::MUL_MUL, exe_pkg::WB_ALU,
			mem_pkg::MEM_SW, 32'h10, 32'h5678, 32'd3, 32'd0, 5'd0, e);
		drain();
		if (req_count != reqs0)
		begin
			$display("A misaligned access raised mem_req");
			errors++;
		end
		report("misaligned", err0);
	endtask

	// Four-phase responder with a random ack delay
	always @(negedge clk)
	begin
		if (!nrst)
			mem_ack <= 1'b0;
		else if (mem_req && !mem_ack)
		begin
			if (delay_left < 0)
			begin
				delay_left = $unsigned($random(ack_seed)) % 6;
				req_count++;
			end
			if (delay_left == 0)
			begin
				if (mem_addr > 32'd255)
				begin
					$display("Memory request outside the 64-word array at %h", mem_addr);
					errors++;
				end
				if (mem_we)
					case (mem_size)
						mem_pkg::SIZE_BYTE:
							resp_mem[mem_addr[7:2]][8*mem_addr[1:0] +: 8] =
								mem_wdata[8*mem_addr[1:0] +: 8];
						mem_pkg::SIZE_HALF:
							resp_mem[mem_addr[7:2]][16*mem_addr[1] +: 16] =
								mem_wdata[16*mem_addr[1] +: 16];
						default:
							resp_mem[mem_addr[7:2]] = mem_wdata;
					endcase
				mem_rdata <= resp_mem[mem_addr[7:2]];
				mem_ack <= 1'b1;
				delay_left = -1;
			end
			else
				delay_left = delay_left - 1;
		end
		else if (!mem_req && mem_ack)
			mem_ack <= 1'b0;
	end

	// Result monitor, outputs are steady at the falling edge
	always @(negedge clk)
	begin
		if (nrst && (wb_valid || misaligned))
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected wb_valid or misaligned with no instruction in flight");
				errors++;
			end
			else
			begin
				cur = exp_q.pop_front();
				check_flag("wb_valid", cur.wb, wb_valid);
				check_flag("misaligned", cur.mis, misaligned);
				check_flag("redirect", cur.redir, redirect);
				if (cur.wb)
					check_rd("wb_rd", cur.rd, wb_rd);
				if (cur.chk)
					check_data("wb_data", cur.data, wb_data);
				if (cur.redir)
					check_data("target", cur.tgt, target);
				if (cur.due >= 0 && cycles != cur.due)
				begin
					$display("Result came at cycle %0d, expected at cycle %0d", cycles, cur.due);
					errors++;
				end
			end
		end
		else if (nrst && exp_q.size() != 0 && exp_q[0].due >= 0 && cycles > exp_q[0].due)
		begin
			$display("No wb_valid for the instruction due at cycle %0d", exp_q[0].due);
			errors++;
			cur = exp_q.pop_front();
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Run stopped at the cycle limit of %0d", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	initial
	begin
		issue_valid = 1'b0;
		op_a = '0;
		op_b = '0;
		imm = '0;
		pc = '0;
		rd = '0;
		alu_op = exe_pkg::ALU_ADD;
		br_kind = exe_pkg::BR_NONE;
		mul_op = exe_pkg::MUL_MUL;
		wb_sel = exe_pkg::WB_ALU;
		mem_op = mem_pkg::MEM_NONE;
		for (i = 0; i < 64; i++)
		begin
			resp_mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		wait (nrst);
		test_alu();
		test_muldiv();
		test_branch();
		test_upper();
		test_loadstore();
		test_misaligned();
		$display("Tests passed: %0d, tests failed: %0d, errors: %0d", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic nrst
);

	localparam int HALF_PERIOD = 5; // 10 ns clock
	localparam int RST_CYCLES  = 10;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release away from the rising edge
	initial
	begin
		nrst = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
	end

endmodule

//--- hdl/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
	input logic clk,
	input logic nrst,
	input logic issue_valid,
	input logic [exe_pkg::XLEN-1:0] op_a, op_b, imm, pc,
	input logic [exe_pkg::REG_ADDR_W-1:0] rd,
	input exe_pkg::alu_op_e alu_op,
	input exe_pkg::br_kind_e br_kind,
	input exe_pkg::mul_op_e mul_op,
	input exe_pkg::wb_sel_e wb_sel,
	input mem_pkg::mem_op_e mem_op,
	output logic stall,
	output logic wb_valid,
	output logic [exe_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic [exe_pkg::XLEN-1:0] wb_data,
	output logic redirect,
	output logic [exe_pkg::XLEN-1:0] target,
	output logic misaligned,
	output logic mem_req,
	output logic mem_we,
	output mem_pkg::mem_size_e mem_size,
	output logic [mem_pkg::ADDR_W-1:0] mem_addr,
	output logic [mem_pkg::DATA_W-1:0] mem_wdata,
	input logic mem_ack,
	input logic [mem_pkg::DATA_W-1:0] mem_rdata
);

	logic [exe_pkg::XLEN-1:0] p5_a, p5_b, p5_imm, p5_pc;
	exe_pkg::alu_op_e p5_alu_op;
	exe_pkg::br_kind_e p5_br_kind;
	exe_pkg::mul_op_e p5_mul_op;
	mem_pkg::mem_op_e p5_mem_op;
	logic [exe_pkg::XLEN-1:0] alu_res, br_target, md_res, load_data;
	logic br_taken, mem_misaligned, capture;

	exe_ctrl u_ctrl (.*);

	alu u_alu (.alu_op(p5_alu_op), .a(p5_a), .b(p5_b), .res(alu_res));

	branch_unit u_bu (.br_kind(p5_br_kind), .a(p5_a), .b(p5_b), .imm(p5_imm), .pc(p5_pc),
		.taken(br_taken), .target(br_target));

	mul_div u_md (.mul_op(p5_mul_op), .a(p5_a), .b(p5_b), .res(md_res));

	// Base is rs1, store data is rs2
	mem_port u_mem (.clk, .nrst, .mem_op(p5_mem_op), .base(p5_a), .offset(p5_imm),
		.store_src(p5_b), .capture, .mem_req, .mem_ack, .mem_rdata,
		.misaligned(mem_misaligned), .mem_we, .mem_size, .mem_addr, .mem_wdata, .load_data);

endmodule

//--- hdl/exe_ctrl.sv
`timescale 1ns/1ps

module exe_ctrl (
	input logic clk,
	input logic nrst,
	input logic issue_valid,
	input logic [exe_pkg::XLEN-1:0] op_a, op_b, imm, pc,
	input logic [exe_pkg::REG_ADDR_W-1:0] rd,
	input exe_pkg::alu_op_e alu_op,
	input exe_pkg::br_kind_e br_kind,
	input exe_pkg::mul_op_e mul_op,
	input exe_pkg::wb_sel_e wb_sel,
	input mem_pkg::mem_op_e mem_op,
	input logic [exe_pkg::XLEN-1:0] alu_res, br_target, md_res, load_data,
	input logic br_taken, mem_misaligned, mem_ack,
	output logic stall, mem_req, capture,
	output logic [exe_pkg::XLEN-1:0] p5_a, p5_b, p5_imm, p5_pc,
	output exe_pkg::alu_op_e p5_alu_op,
	output exe_pkg::br_kind_e p5_br_kind,
	output exe_pkg::mul_op_e p5_mul_op,
	output mem_pkg::mem_op_e p5_mem_op,
	output logic wb_valid, redirect, misaligned,
	output logic [exe_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic [exe_pkg::XLEN-1:0] wb_data, target
);

	exe_pkg::ctrl_state_e state;
	exe_pkg::wb_sel_e p5_wb_sel;
	logic p5_valid;
	logic [exe_pkg::REG_ADDR_W-1:0] p5_rd;
	logic mem_pend, mem_done, advance, is_store;
	logic [exe_pkg::XLEN-1:0] wb_next;

	assign mem_pend = p5_valid && (p5_mem_op != mem_pkg::MEM_NONE) && !mem_misaligned;
	assign mem_done = (state == exe_pkg::ST_RELEASE) && !mem_ack; // Ack dropped
	assign stall    = mem_pend && !mem_done;
	assign advance  = p5_valid && !stall;
	assign mem_req  = state == exe_pkg::ST_REQ;
	assign capture  = mem_req && mem_ack;
	assign is_store = p5_mem_op inside {mem_pkg::MEM_SB, mem_pkg::MEM_SH, mem_pkg::MEM_SW};

	// Four-phase handshake
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= exe_pkg::ST_IDLE;
		else
			case (state)
				exe_pkg::ST_IDLE:    if (mem_pend) state <= exe_pkg::ST_REQ;
				exe_pkg::ST_REQ:     if (mem_ack) state <= exe_pkg::ST_RELEASE;
				exe_pkg::ST_RELEASE: if (!mem_ack) state <= exe_pkg::ST_IDLE;
				default:             state <= exe_pkg::ST_IDLE;
			endcase
	end

	// Pipe 5 holds while stalled
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			p5_valid   <= 1'b0;
			p5_alu_op  <= exe_pkg::ALU_ADD;
			p5_br_kind <= exe_pkg::BR_NONE;
			p5_mul_op  <= exe_pkg::MUL_MUL;
			p5_wb_sel  <= exe_pkg::WB_ALU;
			p5_mem_op  <= mem_pkg::MEM_NONE;
		end
		else if (!stall)
		begin
			p5_valid   <= issue_valid;
			p5_alu_op  <= alu_op;
			p5_br_kind <= br_kind;
			p5_mul_op  <= mul_op;
			p5_wb_sel  <= wb_sel;
			p5_mem_op  <= mem_op;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			p5_a   <= op_a;
			p5_b   <= op_b;
			p5_imm <= imm;
			p5_pc  <= pc;
			p5_rd  <= rd;
		end
	end

	always_comb
	begin
		case (p5_wb_sel)
			exe_pkg::WB_ALU:    wb_next = alu_res;
			exe_pkg::WB_LINK:   wb_next = p5_pc + exe_pkg::PC_STEP;
			exe_pkg::WB_MULDIV: wb_next = md_res;
			exe_pkg::WB_LUI:    wb_next = p5_imm;
			exe_pkg::WB_MEM:    wb_next = load_data;
			exe_pkg::WB_AUIPC:  wb_next = p5_pc + p5_imm;
			default:            wb_next = '0;
		endcase
	end

	// Pipe 6 drains while pipe 5 is stalled
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wb_valid   <= 1'b0;
			redirect   <= 1'b0;
			misaligned <= 1'b0;
		end
		else
		begin
			wb_valid   <= advance && !mem_misaligned;
			redirect   <= advance && br_taken;
			misaligned <= advance && mem_misaligned;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_rd   <= is_store ? '0 : p5_rd; // Stores report rd zero
		wb_data <= wb_next;
		target  <= br_target;
	end

	// Responder side of the four-phase handshake
	a_ack_rise: assert property (@(posedge clk) disable iff (!nrst)
		$rose(mem_ack) |-> mem_req);
	a_ack_fall: assert property (@(posedge clk) disable iff (!nrst)
		$fell(mem_ack) |-> !mem_req);

endmodule

//--- hdl/mem_port.sv
`timescale 1ns/1ps

module mem_port (
	input logic clk,
	input logic nrst,
	input mem_pkg::mem_op_e mem_op,
	input logic [exe_pkg::XLEN-1:0] base,
	input logic [exe_pkg::XLEN-1:0] offset,
	input logic [exe_pkg::XLEN-1:0] store_src,
	input logic capture,
	input logic mem_req,
	input logic mem_ack,
	input logic [mem_pkg::DATA_W-1:0] mem_rdata,
	output logic misaligned,
	output logic mem_we,
	output mem_pkg::mem_size_e mem_size,
	output logic [mem_pkg::ADDR_W-1:0] mem_addr,
	output logic [mem_pkg::DATA_W-1:0] mem_wdata,
	output logic [exe_pkg::XLEN-1:0] load_data
);

	logic [exe_pkg::XLEN-1:0] addr;
	logic [mem_pkg::DATA_W-1:0] rdata_q;
	logic [mem_pkg::DATA_W-1:0] shifted;

	assign addr = base + offset;
	assign mem_addr = addr[mem_pkg::ADDR_W-1:0];

	always_comb
	begin
		case (mem_op)
			mem_pkg::MEM_LB, mem_pkg::MEM_LBU, mem_pkg::MEM_SB:
				mem_size = mem_pkg::SIZE_BYTE;
			mem_pkg::MEM_LH, mem_pkg::MEM_LHU, mem_pkg::MEM_SH:
				mem_size = mem_pkg::SIZE_HALF;
			default:
				mem_size = mem_pkg::SIZE_WORD;
		endcase
	end

	assign mem_we = mem_op inside {mem_pkg::MEM_SB, mem_pkg::MEM_SH, mem_pkg::MEM_SW};

	// Byte accesses can never be misaligned
	assign misaligned = (mem_op != mem_pkg::MEM_NONE) &&
		(((mem_size == mem_pkg::SIZE_HALF) && addr[0]) ||
		((mem_size == mem_pkg::SIZE_WORD) && (addr[1:0] != 2'b00)));

	// Same data on every lane, responder picks by address
	always_comb
	begin
		case (mem_size)
			mem_pkg::SIZE_BYTE: mem_wdata = {4{store_src[7:0]}};
			mem_pkg::SIZE_HALF: mem_wdata = {2{store_src[15:0]}};
			default:            mem_wdata = store_src[mem_pkg::DATA_W-1:0];
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			rdata_q <= mem_rdata; // Held until pipe 6 takes it
	end

	assign shifted = rdata_q >> {addr[1:0], 3'b000};

	always_comb
	begin
		case (mem_op)
			mem_pkg::MEM_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
			mem_pkg::MEM_LBU: load_data = {24'b0, shifted[7:0]};
			mem_pkg::MEM_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
			mem_pkg::MEM_LHU: load_data = {16'b0, shifted[15:0]};
			default:          load_data = rdata_q;
		endcase
	end

	// Request phase must see a steady address from the control FSM
	a_addr_stable: assert property (@(posedge clk) disable iff (!nrst)
		mem_req && !mem_ack |=> $stable(mem_addr));

endmodule

//--- hdl/mul_div.sv
`timescale 1ns/1ps

module mul_div (
	input exe_pkg::mul_op_e mul_op,
	input logic [exe_pkg::XLEN-1:0] a,
	input logic [exe_pkg::XLEN-1:0] b,
	output logic [exe_pkg::XLEN-1:0] res
);

	localparam int W = exe_pkg::XLEN;

	logic signed [2*W-1:0] prod_ss, prod_su;
	logic [2*W-1:0] prod_uu;
	logic div_zero, overflow;

	assign prod_ss = $signed(a) * $signed(b);
	assign prod_su = $signed({{W{a[W-1]}}, a}) * $signed({{W{1'b0}}, b}); // a signed, b unsigned
	assign prod_uu = {{W{1'b0}}, a} * {{W{1'b0}}, b};

	assign div_zero = b == '0;
	assign overflow = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1); // Most negative / -1

	always_comb
	begin
		case (mul_op)
			exe_pkg::MUL_MUL:    res = prod_ss[W-1:0];
			exe_pkg::MUL_MULH:   res = prod_ss[2*W-1:W];
			exe_pkg::MUL_MULHSU: res = prod_su[2*W-1:W];
			exe_pkg::MUL_MULHU:  res = prod_uu[2*W-1:W];
			exe_pkg::MUL_DIV:
				if (div_zero) res = '1;
				else if (overflow) res = a;
				else res = $signed(a) / $signed(b);
			exe_pkg::MUL_DIVU:
				res = div_zero ? '1 : a / b;
			exe_pkg::MUL_REM:
				if (div_zero) res = a;
				else if (overflow) res = '0;
				else res = $signed(a) % $signed(b);
			exe_pkg::MUL_REMU:
				res = div_zero ? a : a % b;
			default: res = '0;
		endcase
	end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input exe_pkg::br_kind_e br_kind,
	input logic [exe_pkg::XLEN-1:0] a,
	input logic [exe_pkg::XLEN-1:0] b,
	input logic [exe_pkg::XLEN-1:0] imm,
	input logic [exe_pkg::XLEN-1:0] pc,
	output logic taken,
	output logic [exe_pkg::XLEN-1:0] target
);

	logic eq, lt, ltu;
	logic [exe_pkg::XLEN-1:0] jr_sum;

	assign eq  = a == b;
	assign lt  = $signed(a) < $signed(b);
	assign ltu = a < b;

	always_comb
	begin
		case (br_kind)
			exe_pkg::BR_BEQ:  taken = eq;
			exe_pkg::BR_BNE:  taken = !eq;
			exe_pkg::BR_BLT:  taken = lt;
			exe_pkg::BR_BGE:  taken = !lt;
			exe_pkg::BR_BLTU: taken = ltu;
			exe_pkg::BR_BGEU: taken = !ltu;
			exe_pkg::BR_JAL, exe_pkg::BR_JALR:
				taken = 1'b1; // Jumps always go
			default: taken = 1'b0;
		endcase
	end

	// jalr target is register relative with bit 0 dropped
	assign jr_sum = a + imm;
	assign target = (br_kind == exe_pkg::BR_JALR) ? {jr_sum[exe_pkg::XLEN-1:1], 1'b0} : pc + imm;

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input exe_pkg::alu_op_e alu_op,
	input logic [exe_pkg::XLEN-1:0] a,
	input logic [exe_pkg::XLEN-1:0] b,
	output logic [exe_pkg::XLEN-1:0] res
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // Low five bits only

	always_comb
	begin
		case (alu_op)
			exe_pkg::ALU_ADD:
				res = a + b;
			exe_pkg::ALU_SUB:
				res = a - b;
			exe_pkg::ALU_SLL:
				res = a << shamt;
			exe_pkg::ALU_SLT:
				res = {{(exe_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			exe_pkg::ALU_SLTU:
				res = {{(exe_pkg::XLEN-1){1'b0}}, a < b};
			exe_pkg::ALU_XOR:
				res = a ^ b;
			exe_pkg::ALU_SRL:
				res = a >> shamt;
			exe_pkg::ALU_SRA:
				res = $signed(a) >>> shamt; // Sign fill
			exe_pkg::ALU_OR:
				res = a | b;
			exe_pkg::ALU_AND:
				res = a & b;
			default:
				res = '0;
		endcase
	end

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Load and store opcodes
	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} mem_size_e;

endpackage

//--- hdl/exe_pkg.sv
package exe_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int PC_STEP    = 4; // Link value is pc + 4

	// Integer ALU operations
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// Control transfer kinds
	typedef enum logic [3:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_JAL,
		BR_JALR
	} br_kind_e;

	typedef enum logic [2:0] {
		MUL_MUL,
		MUL_MULH,
		MUL_MULHSU,
		MUL_MULHU,
		MUL_DIV,
		MUL_DIVU,
		MUL_REM,
		MUL_REMU
	} mul_op_e;

	typedef enum logic [2:0] {WB_ALU, WB_LINK, WB_MULDIV, WB_LUI, WB_MEM, WB_AUIPC} wb_sel_e;

	// Memory handshake FSM
	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RELEASE} ctrl_state_e;

endpackage
